//--- cache_sys.f
source/cache_pkg.sv
source/cache_lookup.sv
source/cache_ctrl.sv
source/cache_data_array.sv
source/line_mem.sv
source/cache_sys.sv
dv/cache_checker.sv
dv/cache_sys_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := cache_sys_tb
FILELIST := cache_sys.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG) || ! grep -q '>>> PASS' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/cache_sys_tb.sv
`timescale 1ns/1ps

module cache_sys_tb;

   localparam int MEM_LATENCY  = 3;        // Long enough for bank stalls on writeback
   localparam int RESET_CYCLES = 8;
   localparam int IDLE_CYCLES  = 10;
   localparam int N_DIRECTED   = 18;
   localparam int N_RANDOM     = 400;
   localparam int WATCHDOG_CYCLES =
      RESET_CYCLES + 2 * IDLE_CYCLES + 200 * (N_DIRECTED + N_RANDOM);

   logic        clk;
   logic        rst_n;
   logic [15:0] addr;
   logic [15:0] data_in;
   logic        read;
   logic        write;
   logic [15:0] data_out;
   logic        done;
   logic        cache_hit;
   logic        stall;
   logic        err;
   int          errors;
   int          checks;
   integer      seed;

   cache_sys #(
      .MEM_LATENCY (MEM_LATENCY)
   ) u_cache_sys (
      .clk       (clk),
      .rst_n     (rst_n),
      .addr      (addr),
      .data_in   (data_in),
      .read      (read),
      .write     (write),
      .data_out  (data_out),
      .done      (done),
      .cache_hit (cache_hit),
      .stall     (stall),
      .err       (err)
   );

   cache_checker #(
      .MEM_LATENCY (MEM_LATENCY)
   ) u_checker (
      .clk       (clk),
      .rst_n     (rst_n),
      .addr      (addr),
      .data_in   (data_in),
      .read      (read),
      .write     (write),
      .data_out  (data_out),
      .done      (done),
      .cache_hit (cache_hit),
      .stall     (stall),
      .err       (err),
      .errors    (errors),
      .checks    (checks)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic issue_request(input logic [15:0] a, input logic [15:0] d,
                                input logic rd, input logic wr);
      @(negedge clk);
      addr    = a;
      data_in = d;
      read    = rd;
      write   = wr;
      @(posedge clk);
      while (!done) @(posedge clk);        // Held until the done pulse
   endtask

   task automatic hold_idle(input int cycles);
      @(negedge clk);
      read  = 1'b0;
      write = 1'b0;
      repeat (cycles) @(posedge clk);
   endtask

   initial begin
      logic [31:0] r;
      logic [15:0] a;
      logic        both;
      rst_n   = 1'b0;
      addr    = 16'h0000;
      data_in = 16'h0000;
      read    = 1'b0;
      write   = 1'b0;
      seed    = 32'h20f0_ab15;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      hold_idle(IDLE_CYCLES);

      issue_request(16'h0100, 16'h1234, 1'b0, 1'b1);   // Same and neighboring words
      issue_request(16'h0102, 16'habcd, 1'b0, 1'b1);
      issue_request(16'h0100, 16'h0000, 1'b1, 1'b0);
      issue_request(16'h0102, 16'h0000, 1'b1, 1'b0);
      issue_request(16'h0104, 16'h0000, 1'b1, 1'b0);
      issue_request(16'h0106, 16'h0000, 1'b1, 1'b0);
      issue_request(16'h2008, 16'h0000, 1'b1, 1'b0);   // Miss, then hits in the line
      issue_request(16'h200a, 16'h0000, 1'b1, 1'b0);
      issue_request(16'h200c, 16'h7e01, 1'b0, 1'b1);
      issue_request(16'h0840, 16'h5a5a, 1'b0, 1'b1);   // Index 8, tags 1 and 2
      issue_request(16'h1040, 16'h0000, 1'b1, 1'b0);
      issue_request(16'h0840, 16'h0000, 1'b1, 1'b0);
      issue_request(16'h1040, 16'hc3c3, 1'b0, 1'b1);
      issue_request(16'h0840, 16'h0000, 1'b1, 1'b0);
      issue_request(16'h0841, 16'h0000, 1'b1, 1'b0);   // Odd address
      issue_request(16'h0841, 16'hffff, 1'b0, 1'b1);
      issue_request(16'h0840, 16'h0bad, 1'b1, 1'b1);   // Both strobes
      issue_request(16'h0840, 16'h0000, 1'b1, 1'b0);

      // Four tags over four indices, some odd or double strobes
      for (int i = 0; i < N_RANDOM; i++) begin
         r    = $random(seed);
         a    = {3'b000, r[1:0], 6'b000000, r[3:2], r[5:4], r[11:8] == 4'h0};
         both = (r[15:12] == 4'h0);
         issue_request(a, r[31:16], ~r[6] | both, r[6] | both);
      end

      hold_idle(IDLE_CYCLES);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0 && checks > 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display(">>> FAIL");
      $finish;
   end

endmodule

//--- dv/cache_checker.sv
`timescale 1ns/1ps

module cache_checker #(
   parameter int MEM_LATENCY = 2
) (
   input  logic        clk,
   input  logic        rst_n,
   input  logic [15:0] addr,
   input  logic [15:0] data_in,
   input  logic        read,
   input  logic        write,
   input  logic [15:0] data_out,
   input  logic        done,
   input  logic        cache_hit,
   input  logic        stall,
   input  logic        err,
   output int          errors,
   output int          checks
);

   logic [15:0] ref_mem [32768];           // Flat word memory seen by the processor
   logic        line_valid [256];
   logic        line_dirty [256];
   logic [4:0]  line_tag [256];
   int          waited;                    // Stall cycles of the current request

   initial begin
      errors     = 0;
      checks     = 0;
      waited     = 0;
      ref_mem    = '{default: '0};
      line_valid = '{default: 1'b0};
      line_dirty = '{default: 1'b0};
      line_tag   = '{default: '0};
   end

   function automatic logic [15:0] expected_word(input logic [15:0] byte_addr);
      return ref_mem[byte_addr[15:1]];
   endfunction

   function automatic logic expected_hit(input logic [15:0] byte_addr);
      return line_valid[byte_addr[10:3]] && (line_tag[byte_addr[10:3]] == byte_addr[15:11]);
   endfunction

   task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error: %s = %h, expected %h (addr %h) at %0t", name, got, exp, addr, $time);
      end
   endtask

   task automatic report_failure(input string what);
      errors++;
      $display("Failure at %0t: %s (addr %h, waited %0d cycles)", $time, what, addr, waited);
   endtask

   always @(posedge clk) begin : compare_on_edge
      logic [7:0] idx;
      logic       bad;
      logic       hit;
      int         min_wait;
      if (rst_n) begin
         idx = addr[10:3];
         bad = addr[0] | (read & write);
         hit = ~bad & expected_hit(addr);
         if (!read && !write) begin                // Quiet outputs without a request
            check_value("done", {15'b0, done}, 16'h0);
            check_value("stall", {15'b0, stall}, 16'h0);
            check_value("cache_hit", {15'b0, cache_hit}, 16'h0);
            check_value("err", {15'b0, err}, 16'h0);
            waited = 0;
         end else if (!done) begin
            check_value("stall", {15'b0, stall}, 16'h1);
            waited++;
         end else begin
            check_value("err", {15'b0, err}, {15'b0, bad});
            check_value("cache_hit", {15'b0, cache_hit}, {15'b0, hit});
            check_value("stall", {15'b0, stall}, 16'h0);
            if (bad || hit) begin
               if (waited != 0) report_failure("done was late for a hit or a bad request");
            end else begin
               // Issue, memory latency and replay, plus writeback of a dirty victim
               min_wait = 4 + MEM_LATENCY + 1 + ((line_valid[idx] && line_dirty[idx]) ? 4 : 0);
               if (waited < min_wait) report_failure("miss finished faster than memory allows");
            end
            if (!bad) begin
               if (read) begin
                  check_value("data_out", data_out, expected_word(addr));
               end else begin
                  ref_mem[addr[15:1]] = data_in;
               end
               line_dirty[idx] = write | (hit & line_dirty[idx]);
               line_valid[idx] = 1'b1;
               line_tag[idx]   = addr[15:11];
            end
            waited = 0;
         end
      end
   end

endmodule

//--- source/cache_sys.sv
`timescale 1ns/1ps

module cache_sys #(
   parameter int MEM_LATENCY = 2
) (
   input  logic        clk,
   input  logic        rst_n,
   input  logic [15:0] addr,
   input  logic [15:0] data_in,
   input  logic        read,
   input  logic        write,
   output logic [15:0] data_out,
   output logic        done,
   output logic        cache_hit,
   output logic        stall,
   output logic        err
);

   cache_pkg::cache_req_t req;
   cache_pkg::lookup_t    look;
   cache_pkg::mem_req_t   mem_req;

   logic        tag_wr;
   logic        set_dirty;
   logic        data_wr;
   logic [1:0]  fill_word;
   logic        use_fill;
   logic        mem_stall;
   logic        rd_valid;
   logic [15:0] rd_data;

   cache_lookup u_lookup (
      .clk       (clk),
      .rst_n     (rst_n),
      .addr      (addr),
      .data_in   (data_in),
      .read      (read),
      .write     (write),
      .tag_wr    (tag_wr),
      .set_dirty (set_dirty),
      .req       (req),
      .look      (look)
   );

   cache_ctrl u_ctrl (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (req),
      .look      (look),
      .mem_stall (mem_stall),
      .rd_valid  (rd_valid),
      .rd_word   (data_out),               // Victim data for writeback
      .done      (done),
      .cache_hit (cache_hit),
      .stall     (stall),
      .err       (err),
      .tag_wr    (tag_wr),
      .set_dirty (set_dirty),
      .data_wr   (data_wr),
      .fill_word (fill_word),
      .use_fill  (use_fill),
      .mem       (mem_req)
   );

   cache_data_array u_data (
      .clk         (clk),
      .req         (req),
      .data_wr     (data_wr),
      .use_fill    (use_fill),
      .fill_word   (fill_word),
      .fill_data   (rd_data),
      .victim_word (fill_word),            // Word select for the read port
      .rd_word     (data_out)
   );

   line_mem #(
      .MEM_LATENCY (MEM_LATENCY)
   ) u_mem (
      .clk       (clk),
      .rst_n     (rst_n),
      .mem       (mem_req),
      .mem_stall (mem_stall),
      .rd_valid  (rd_valid),
      .rd_data   (rd_data)
   );

endmodule

//--- source/line_mem.sv
`timescale 1ns/1ps

module line_mem #(
   parameter int MEM_LATENCY = 2
) (
   input  logic                clk,
   input  logic                rst_n,
   input  cache_pkg::mem_req_t mem,
   output logic                mem_stall,
   output logic                rd_valid,
   output logic [15:0]         rd_data
);

   localparam int WORDS = 32768;
   localparam int CNT_W = $clog2(MEM_LATENCY + 2);

   logic [15:0]      words [WORDS];
   logic [CNT_W-1:0] busy_cnt [4];         // Per-bank countdown
   logic             vld_pipe [MEM_LATENCY];
   logic [15:0]      dat_pipe [MEM_LATENCY];
   logic [1:0]       bank;
   logic             accept;

   initial begin
      words = '{default: '0};
   end

   assign bank      = mem.addr[1:0];
   assign mem_stall = (mem.rd | mem.wr) & (busy_cnt[bank] != '0);
   assign accept    = (mem.rd | mem.wr) & ~mem_stall;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int b = 0; b < 4; b++) begin
            busy_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < 4; b++) begin
            if (accept && bank == b[1:0]) begin
               busy_cnt[b] <= CNT_W'(MEM_LATENCY + 1);
            end else if (busy_cnt[b] != '0) begin
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept && mem.wr) begin
         words[mem.addr[14:0]] <= mem.data;
      end
   end

   // Read return pipeline
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < MEM_LATENCY; i++) begin
            vld_pipe[i] <= 1'b0;
         end
      end else begin
         for (int i = MEM_LATENCY - 1; i > 0; i--) begin
            vld_pipe[i] <= vld_pipe[i-1];
         end
         vld_pipe[0] <= accept & mem.rd;
      end
   end

   always_ff @(posedge clk) begin
      for (int i = MEM_LATENCY - 1; i > 0; i--) begin
         dat_pipe[i] <= dat_pipe[i-1];
      end
      dat_pipe[0] <= words[mem.addr[14:0]];
   end

   assign rd_valid = vld_pipe[MEM_LATENCY-1];
   assign rd_data  = dat_pipe[MEM_LATENCY-1];

endmodule

//--- source/cache_data_array.sv
`timescale 1ns/1ps

module cache_data_array (
   input  logic                  clk,
   input  cache_pkg::cache_req_t req,
   input  logic                  data_wr,
   input  logic                  use_fill,
   input  logic [1:0]            fill_word,
   input  logic [15:0]           fill_data,
   input  logic [1:0]            victim_word,
   output logic [15:0]           rd_word
);

   localparam int DEPTH  = cache_pkg::LINES * cache_pkg::LINE_WORDS;
   localparam int ADDR_W = cache_pkg::INDEX_W + cache_pkg::WORD_W;

   logic [15:0] words [DEPTH];             // Line-major, four words per line

   logic [cache_pkg::WORD_W-1:0] wr_word;
   logic [15:0]                  wr_data;
   logic [ADDR_W-1:0]            wr_addr;
   logic [ADDR_W-1:0]            rd_addr;

   // Fill path from memory or store path from the processor
   assign wr_word = use_fill ? fill_word : req.word;
   assign wr_data = use_fill ? fill_data : req.wdata;

   assign wr_addr = {req.index, wr_word};
   assign rd_addr = {req.index, victim_word};

   always_ff @(posedge clk) begin
      if (data_wr) begin
         words[wr_addr] <= wr_data;
      end
   end

   assign rd_word = words[rd_addr];       // Async read

endmodule

//--- source/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl (
   input  logic                  clk,
   input  logic                  rst_n,
   input  cache_pkg::cache_req_t req,
   input  cache_pkg::lookup_t    look,
   input  logic                  mem_stall,
   input  logic                  rd_valid,
   input  logic [15:0]           rd_word,
   output logic                  done,
   output logic                  cache_hit,
   output logic                  stall,
   output logic                  err,
   output logic                  tag_wr,
   output logic                  set_dirty,
   output logic                  data_wr,
   output logic [1:0]            fill_word,
   output logic                  use_fill,
   output cache_pkg::mem_req_t   mem
);

   cache_pkg::ctrl_state_e state;
   cache_pkg::ctrl_state_e nxt_state;

   logic [1:0] issue_cnt;                  // Words accepted by memory
   logic [1:0] ret_cnt;                    // Words returned by memory
   logic       active;
   logic       issue_ok;

   assign active   = req.rd | req.wr;
   assign issue_ok = (mem.rd | mem.wr) & ~mem_stall;

   always_comb begin
      nxt_state = state;
      done      = 1'b0;
      cache_hit = 1'b0;
      stall     = 1'b1;
      err       = 1'b0;
      tag_wr    = 1'b0;
      set_dirty = 1'b0;
      data_wr   = 1'b0;
      use_fill  = 1'b0;
      fill_word = req.word;                // Also selects the read word
      mem       = '0;

      // Returned words land in the line as they arrive
      if (rd_valid) begin
         data_wr   = 1'b1;
         use_fill  = 1'b1;
         fill_word = ret_cnt;
      end

      case (state)
         cache_pkg::IDLE: begin
            stall = 1'b0;
            if (active) begin
               if (look.bad_req) begin
                  done = 1'b1;
                  err  = 1'b1;
               end else if (look.hit) begin
                  done      = 1'b1;
                  cache_hit = 1'b1;
                  data_wr   = req.wr;
                  tag_wr    = req.wr;
                  set_dirty = req.wr;
               end else begin
                  stall     = 1'b1;
                  nxt_state = cache_pkg::EVICT_SETUP;
               end
            end
         end
         cache_pkg::EVICT_SETUP: begin
            nxt_state = (look.valid & look.dirty) ? cache_pkg::MEM_WR : cache_pkg::MEM_RD;
         end
         cache_pkg::MEM_WR: begin
            mem.wr    = 1'b1;
            mem.addr  = {1'b0, look.victim_tag, req.index, issue_cnt};
            mem.data  = rd_word;
            fill_word = issue_cnt;         // Victim word on the read port
            if (!mem_stall && issue_cnt == 2'd3) begin
               nxt_state = cache_pkg::MEM_RD;
            end
         end
         cache_pkg::MEM_RD: begin
            mem.rd   = 1'b1;
            mem.addr = {1'b0, req.tag, req.index, issue_cnt};
            if (!mem_stall && issue_cnt == 2'd3) begin
               nxt_state = cache_pkg::FILL_WAIT;
            end
         end
         cache_pkg::FILL_WAIT: begin
            // Last word in, line becomes valid and clean
            if (rd_valid && ret_cnt == 2'd3) begin
               tag_wr    = 1'b1;
               set_dirty = 1'b0;
               nxt_state = cache_pkg::REFILL_LAST;
            end
         end
         cache_pkg::REFILL_LAST: begin
            nxt_state = look.hit ? cache_pkg::REPLAY : cache_pkg::EVICT_SETUP;
         end
         cache_pkg::REPLAY: begin
            stall     = 1'b0;
            done      = 1'b1;
            data_wr   = req.wr;
            tag_wr    = req.wr;
            set_dirty = req.wr;
            nxt_state = cache_pkg::IDLE;
         end
         default: begin
            nxt_state = cache_pkg::IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= cache_pkg::IDLE;
         issue_cnt <= '0;
         ret_cnt   <= '0;
      end else begin
         state <= nxt_state;
         if (state == cache_pkg::EVICT_SETUP) begin
            issue_cnt <= '0;
            ret_cnt   <= '0;
         end else begin
            if (issue_ok) begin
               issue_cnt <= issue_cnt + 2'd1;
            end
            if (rd_valid) begin
               ret_cnt <= ret_cnt + 2'd1;
            end
         end
      end
   end

endmodule

//--- source/cache_lookup.sv
`timescale 1ns/1ps

module cache_lookup (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic [15:0]           addr,
   input  logic [15:0]           data_in,
   input  logic                  read,
   input  logic                  write,
   input  logic                  tag_wr,
   input  logic                  set_dirty,
   output cache_pkg::cache_req_t req,
   output cache_pkg::lookup_t    look
);

   logic [cache_pkg::TAG_W-1:0] tag_mem [cache_pkg::LINES];
   logic [cache_pkg::LINES-1:0] valid_q;
   logic [cache_pkg::LINES-1:0] dirty_q;
   logic [cache_pkg::TAG_W-1:0] stored_tag;

   // Field split of the byte address
   always_comb begin
      req.tag   = addr[15:11];
      req.index = addr[10:3];
      req.word  = addr[2:1];
      req.wdata = data_in;
      req.rd    = read;
      req.wr    = write;
   end

   assign stored_tag = tag_mem[req.index];

   always_comb begin
      look.valid      = valid_q[req.index];
      look.dirty      = dirty_q[req.index];
      look.victim_tag = stored_tag;
      look.hit        = valid_q[req.index] & (stored_tag == req.tag);
      look.bad_req    = addr[0] | (read & write);    // Odd address or both strobes
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (tag_wr) begin
         valid_q[req.index] <= 1'b1;
         dirty_q[req.index] <= set_dirty;
      end
   end

   always_ff @(posedge clk) begin
      if (tag_wr) begin
         tag_mem[req.index] <= req.tag;
      end
   end

endmodule

//--- source/cache_pkg.sv
package cache_pkg;

   // Address split of a 16-bit byte address
   localparam int TAG_W   = 5;             // addr[15:11]
   localparam int INDEX_W = 8;             // addr[10:3]
   localparam int WORD_W  = 2;             // addr[2:1]

   localparam int LINES      = 256;
   localparam int LINE_WORDS = 4;

   typedef enum logic [2:0] {
      IDLE,
      EVICT_SETUP,
      MEM_WR,
      MEM_RD,
      FILL_WAIT,
      REFILL_LAST,
      REPLAY
   } ctrl_state_e;

   // Decoded processor request
   typedef struct packed {
      logic [TAG_W-1:0]   tag;
      logic [INDEX_W-1:0] index;
      logic [WORD_W-1:0]  word;
      logic [15:0]        wdata;
      logic               rd;
      logic               wr;
   } cache_req_t;

   typedef struct packed {
      logic             hit;
      logic             valid;
      logic             dirty;
      logic [TAG_W-1:0] victim_tag;        // Tag currently stored at the index
      logic             bad_req;
   } lookup_t;

   typedef struct packed {
      logic [15:0] addr;                   // Word address
      logic [15:0] data;
      logic        rd;
      logic        wr;
   } mem_req_t;

endpackage
